/* rtl/rx_link_pkg.sv */
// Widths are fixed by the TLK2711 16-bit word and the 64-bit DMA port and are not parameters
package rx_link_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // One SerDes word, one DMA beat
    typedef logic [15:0] rx_word_t;
    typedef logic [63:0] beat_t;

    // Frame length in bytes and line number from the header
    typedef logic [15:0] byte_len_t;
    typedef logic [23:0] line_num_t;

    // DDR byte address
    typedef logic [31:0] addr_t;

    //////////////////////////////
    // Code words
    //////////////////////////////

    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    localparam logic [7:0] K28_2 = 8'h5C;
    localparam logic [7:0] K27_7 = 8'hFB;

    // Idle sync carries a K only in the lower byte
    localparam rx_word_t SYNC_WORD = {D5_6, K28_5};
    // Start of frame has both bytes as K
    localparam rx_word_t SOF_WORD  = {K28_2, K27_7};
    // Sent by the TLK2711 with both K flags when the link drops
    localparam rx_word_t LINK_LOSS_WORD = 16'hFFFF;

    // Upper half arrives first
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'hEB90_E116;

    //////////////////////////////
    // Parser states and stage data
    //////////////////////////////

    typedef enum logic [3:0] {
        IDLE,
        SYNC,
        HEAD,
        TYPE,
        LINE,
        LENGTH,
        DATA,
        CHECK,
        END1,
        END2
    } rx_state_e;

    typedef struct packed {
        logic     kmsb;
        logic     klsb;
        rx_word_t data;
    } serdes_in_t;

    // last marks the final payload word of a frame
    typedef struct packed {
        logic     valid;
        logic     last;
        rx_word_t data;
    } payload_t;

    typedef struct packed {
        logic      file_end;
        logic [1:0] channel_id;
        logic [3:0] data_type;
        line_num_t line_number;
        byte_len_t length;
        logic      checksum_error;
    } frame_info_t;

endpackage

/* rtl/frame_parser.sv */
// Expects one SerDes word per clk with no gaps inside a frame and an even, nonzero LENGTH field
`timescale 1ns/1ps

module frame_parser (
    input  logic                     clk,
    input  logic                     i_reset,
    input  rx_link_pkg::serdes_in_t  i_in,
    output rx_link_pkg::payload_t    o_payload,
    output logic                     o_length_strobe,
    output rx_link_pkg::byte_len_t   o_length,
    output logic                     o_frame_end,
    output rx_link_pkg::frame_info_t o_frame_info
);
    import rx_link_pkg::*;

    rx_state_e   state;
    rx_state_e   state_next;
    rx_word_t    prev_word;
    rx_word_t    checksum;
    logic [14:0] data_cnt;
    logic        data_done;
    logic        is_sync;
    logic        is_sof;
    frame_info_t info_q;
    payload_t    payload_q;
    logic        length_strobe_q;
    logic        frame_end_q;

    assign is_sync   = !i_in.kmsb && i_in.klsb && (i_in.data == SYNC_WORD);
    assign is_sof    = i_in.kmsb && i_in.klsb && (i_in.data == SOF_WORD);
    // Payload is length/2 words
    assign data_done = (data_cnt == info_q.length[15:1] - 15'd1);

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (is_sync) begin
                    state_next = SYNC;
                end
            end
            SYNC: begin
                if (is_sof) begin
                    state_next = HEAD;
                end
            end
            HEAD: begin
                // Two consecutive words form the head flag
                if ({prev_word, i_in.data} == FRAME_HEAD_FLAG) begin
                    state_next = TYPE;
                end
            end
            TYPE:    state_next = LINE;
            LINE:    state_next = LENGTH;
            LENGTH:  state_next = DATA;
            DATA: begin
                if (data_done) begin
                    state_next = CHECK;
                end
            end
            CHECK:   state_next = END1;
            END1:    state_next = END2;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        prev_word <= i_in.data;
    end

    //////////////////////////////
    // Header decode and checksum
    //////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            TYPE: begin
                // Bit 15 of the file end field is not reported
                info_q.file_end           <= i_in.data[14];
                info_q.channel_id         <= i_in.data[13:12];
                info_q.data_type          <= i_in.data[11:8];
                info_q.line_number[23:16] <= i_in.data[7:0];
                info_q.checksum_error     <= 1'b0;
                checksum                  <= i_in.data;
            end
            LINE: begin
                info_q.line_number[15:0] <= i_in.data;
                checksum                 <= checksum + i_in.data;
            end
            LENGTH: begin
                info_q.length <= i_in.data;
                checksum      <= checksum + i_in.data;
            end
            DATA: begin
                checksum <= checksum + i_in.data;
            end
            CHECK: begin
                info_q.checksum_error <= (checksum != i_in.data);
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // Strobes to the next stages
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            payload_q       <= '0;
            length_strobe_q <= 1'b0;
            frame_end_q     <= 1'b0;
            data_cnt        <= '0;
        end else begin
            payload_q.valid <= (state == DATA);
            payload_q.last  <= (state == DATA) && data_done;
            payload_q.data  <= i_in.data;
            length_strobe_q <= (state == LENGTH);
            // Two cycles after the CHECK word
            frame_end_q     <= (state == END1);
            if (state == DATA) begin
                data_cnt <= data_cnt + 15'd1;
            end else begin
                data_cnt <= '0;
            end
        end
    end

    assign o_payload       = payload_q;
    assign o_length_strobe = length_strobe_q;
    assign o_length        = info_q.length;
    assign o_frame_end     = frame_end_q;
    assign o_frame_info    = info_q;

    a_length_even: assert property (@(posedge clk) disable iff (i_reset)
        o_length_strobe |-> (o_length[0] == 1'b0) && (o_length != '0))
        else $error("frame length %0d is odd or zero", o_length);

endmodule

/* rtl/word_packer.sv */
// Relies on the last flag to close every frame, so a frame cut short leaves a partial beat
`timescale 1ns/1ps

module word_packer (
    input  logic                  clk,
    input  logic                  i_reset,
    input  rx_link_pkg::payload_t i_payload,
    output logic                  o_beat_wr,
    output rx_link_pkg::beat_t    o_beat
);
    import rx_link_pkg::*;

    logic [1:0] lane;
    logic [5:0] lane_lsb;
    beat_t      beat_q;
    logic       beat_wr_q;
    logic       beat_full;

    // Lane n sits at bits 16n+15..16n
    assign lane_lsb  = {lane, 4'b0000};
    assign beat_full = (lane == 2'd3);

    //////////////////////////////
    // Lane control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            lane      <= 2'd0;
            beat_wr_q <= 1'b0;
        end else begin
            beat_wr_q <= i_payload.valid && (beat_full || i_payload.last);
            if (i_payload.valid) begin
                // Next frame starts in lane 0
                if (i_payload.last) begin
                    lane <= 2'd0;
                end else begin
                    lane <= lane + 2'd1;
                end
            end
        end
    end

    //////////////////////////////
    // Beat assembly
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_payload.valid) begin
            if (lane == 2'd0) begin
                // Clearing the upper lanes gives the zero fill on a short last beat
                beat_q <= beat_t'(i_payload.data);
            end else begin
                beat_q[lane_lsb +: 16] <= i_payload.data;
            end
        end
    end

    assign o_beat_wr = beat_wr_q;
    assign o_beat    = beat_q;

endmodule

/* rtl/beat_fifo.sv */
// DEPTH must be a power of two, and a write into a full FIFO is dropped since the link cannot stall
`timescale 1ns/1ps

module beat_fifo #(
    parameter int DEPTH = 2048
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_wr,
    input  rx_link_pkg::beat_t i_beat,
    input  logic               i_dma_wr_ready,
    output logic               o_dma_wr_valid,
    output rx_link_pkg::beat_t o_dma_wr_data
);
    import rx_link_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    beat_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          empty;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign empty = (count == '0);
    assign full  = (count == FULL_COUNT);
    assign wr_en = i_wr && !full;
    // Each valid cycle takes one beat
    assign rd_en = o_dma_wr_valid;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fall-through head beat
    assign o_dma_wr_data  = mem[rd_ptr];
    assign o_dma_wr_valid = !empty && i_dma_wr_ready;

    a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
        i_wr |-> !full)
        else $error("beat written into a full FIFO");

endmodule

/* rtl/dma_cmd_gen.sv */
// One command is outstanding at a time, so the acknowledge must come before the next LENGTH word
`timescale 1ns/1ps

module dma_cmd_gen (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_length_strobe,
    input  rx_link_pkg::byte_len_t i_length,
    input  logic                   i_frame_end,
    input  logic                   i_rx_start,
    input  rx_link_pkg::addr_t     i_rx_base_addr,
    input  logic                   i_wr_cmd_ack,
    output logic                   o_wr_cmd_req,
    output rx_link_pkg::addr_t     o_wr_cmd_addr,
    output rx_link_pkg::byte_len_t o_wr_cmd_bytes
);
    import rx_link_pkg::*;

    addr_t     next_addr;
    addr_t     cmd_addr_q;
    logic      req_q;
    byte_len_t bytes_rounded;

    // DDR writes go in 8-byte beats
    assign bytes_rounded = {i_length[15:3] + 13'(|i_length[2:0]), 3'b000};

    //////////////////////////////
    // Request and running address
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            req_q     <= 1'b0;
            next_addr <= '0;
        end else begin
            req_q <= (i_length_strobe || req_q) && !i_wr_cmd_ack;
            if (i_rx_start) begin
                next_addr <= i_rx_base_addr;
            end else if (i_frame_end) begin
                next_addr <= next_addr + addr_t'(bytes_rounded);
            end
        end
    end

    // Frame end can move the running address before the acknowledge
    always_ff @(posedge clk) begin
        if (i_length_strobe) begin
            cmd_addr_q <= next_addr;
        end
    end

    assign o_wr_cmd_req   = i_length_strobe || req_q;
    assign o_wr_cmd_addr  = i_length_strobe ? next_addr : cmd_addr_q;
    assign o_wr_cmd_bytes = bytes_rounded;

    a_ack_has_req: assert property (@(posedge clk) disable iff (i_reset)
        i_wr_cmd_ack |-> o_wr_cmd_req)
        else $error("write command acknowledge without a request");

endmodule

/* rtl/link_loss_monitor.sv */
// HOLDOFF_CYCLES must be at least 1, and loss words are ignored while i_ena is low
`timescale 1ns/1ps

module link_loss_monitor #(
    parameter int HOLDOFF_CYCLES = 10_000_000
) (
    input  logic                    clk,
    input  logic                    i_reset,
    input  rx_link_pkg::serdes_in_t i_in,
    input  logic                    i_ena,
    output logic                    o_link_loss
);
    import rx_link_pkg::*;

    localparam int CW = $clog2(HOLDOFF_CYCLES + 1);
    localparam logic [CW-1:0] LAST_CNT = CW'(HOLDOFF_CYCLES - 1);

    logic          loss_word;
    logic          detect;
    logic          loss_q;
    logic          holdoff_q;
    logic [CW-1:0] holdoff_cnt;

    assign loss_word = i_in.kmsb && i_in.klsb && (i_in.data == LINK_LOSS_WORD);
    assign detect    = loss_word && !holdoff_q;

    always_ff @(posedge clk) begin
        if (i_reset || !i_ena) begin
            loss_q      <= 1'b0;
            holdoff_q   <= 1'b0;
            holdoff_cnt <= '0;
        end else begin
            loss_q <= detect;
            if (detect) begin
                holdoff_q   <= 1'b1;
                holdoff_cnt <= '0;
            end else if (holdoff_q) begin
                // Hold-off covers HOLDOFF_CYCLES cycles after the pulse starts
                if (holdoff_cnt == LAST_CNT) begin
                    holdoff_q <= 1'b0;
                end
                holdoff_cnt <= holdoff_cnt + 1'b1;
            end
        end
    end

    assign o_link_loss = loss_q;

endmodule

/* rtl/rx_link_top.sv */
// SerDes words must already be in the clk domain, and FIFO_DEPTH must be a power of two
`timescale 1ns/1ps

module rx_link_top #(
    parameter int FIFO_DEPTH     = 2048,
    parameter int HOLDOFF_CYCLES = 10_000_000
) (
    input  logic                     clk,
    input  logic                     i_reset,

    // TLK2711 receive side
    input  logic                     i_rx_kmsb,
    input  logic                     i_rx_klsb,
    input  rx_link_pkg::rx_word_t    i_rxd,

    // Control
    input  logic                     i_rx_start,
    input  rx_link_pkg::addr_t       i_rx_base_addr,
    input  logic                     i_link_loss_ena,

    // DMA write command
    input  logic                     i_wr_cmd_ack,
    output logic                     o_wr_cmd_req,
    output rx_link_pkg::addr_t       o_wr_cmd_addr,
    output rx_link_pkg::byte_len_t   o_wr_cmd_bytes,

    // DMA write data
    input  logic                     i_dma_wr_ready,
    output logic                     o_dma_wr_valid,
    output rx_link_pkg::beat_t       o_dma_wr_data,

    // Frame and link status
    output logic                     o_frame_done,
    output rx_link_pkg::frame_info_t o_frame_info,
    output logic                     o_link_loss
);
    import rx_link_pkg::*;

    serdes_in_t rx_in;
    payload_t   payload;
    logic       beat_wr;
    beat_t      beat;
    logic       length_strobe;
    byte_len_t  length;
    logic       frame_end;

    assign rx_in        = '{kmsb: i_rx_kmsb, klsb: i_rx_klsb, data: i_rxd};
    assign o_frame_done = frame_end;

    //////////////////////////////
    // Data path
    //////////////////////////////

    frame_parser i_frame_parser (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_in            (rx_in),
        .o_payload       (payload),
        .o_length_strobe (length_strobe),
        .o_length        (length),
        .o_frame_end     (frame_end),
        .o_frame_info    (o_frame_info)
    );

    word_packer i_word_packer (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_payload (payload),
        .o_beat_wr (beat_wr),
        .o_beat    (beat)
    );

    beat_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_beat_fifo (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_wr           (beat_wr),
        .i_beat         (beat),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_data  (o_dma_wr_data)
    );

    //////////////////////////////
    // Side branches
    //////////////////////////////

    dma_cmd_gen i_dma_cmd_gen (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_length_strobe (length_strobe),
        .i_length        (length),
        .i_frame_end     (frame_end),
        .i_rx_start      (i_rx_start),
        .i_rx_base_addr  (i_rx_base_addr),
        .i_wr_cmd_ack    (i_wr_cmd_ack),
        .o_wr_cmd_req    (o_wr_cmd_req),
        .o_wr_cmd_addr   (o_wr_cmd_addr),
        .o_wr_cmd_bytes  (o_wr_cmd_bytes)
    );

    link_loss_monitor #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) i_link_loss_monitor (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_in        (rx_in),
        .i_ena       (i_link_loss_ena),
        .o_link_loss (o_link_loss)
    );

endmodule

/* verif/rx_link_tb.sv */
// FIFO_DEPTH and HOLDOFF_CYCLES are cut to 64, so the frame table keeps the FIFO fill below 64 beats
`timescale 1ns/1ps

module rx_link_tb;
    import rx_link_pkg::*;

    localparam int          DEPTH_TB        = 64;
    localparam int          HOLDOFF_TB      = 64;
    localparam logic [31:0] SEED            = 32'h0d26_8d8c;
    localparam logic [31:0] BASE_ADDR       = 32'h0000_1000;
    localparam int          SYNC_COUNT      = 3;
    localparam int          LINK_TEST_WORDS = 82;
    localparam int          RESET_WORDS     = 12;
    localparam int          NUM_ROWS        = 8;

    // Code words as the TLK2711 sends them
    localparam logic [15:0] SYNC_CODE = 16'hC5BC;
    localparam logic [15:0] SOF_CODE  = 16'h5CFB;
    localparam logic [15:0] LOSS_CODE = 16'hFFFF;
    localparam logic [31:0] HEAD_CODE = 32'hEB90_E116;

    typedef struct packed {
        logic [15:0] len;
        logic [3:0]  dtype;
        logic [1:0]  chan;
        logic        fend;
        logic [23:0] line;
        logic        corrupt;
        logic [6:0]  duty;
        logic [7:0]  idle;
        logic        head_first;
    } frame_row_t;

    // len, type, channel, file end, line, corrupt, ready percent, idle words, lone head flag
    localparam frame_row_t ROWS [NUM_ROWS] = '{
        '{16'd8,   4'd1,  2'd0, 1'b0, 24'h000001, 1'b0, 7'd100, 8'd4, 1'b1},
        '{16'd10,  4'd2,  2'd1, 1'b0, 24'h000002, 1'b0, 7'd100, 8'd2, 1'b0},
        '{16'd32,  4'd3,  2'd2, 1'b1, 24'h012345, 1'b1, 7'd60,  8'd1, 1'b0},
        '{16'd2,   4'd15, 2'd3, 1'b0, 24'hABCDEF, 1'b0, 7'd40,  8'd0, 1'b0},
        '{16'd64,  4'd5,  2'd0, 1'b1, 24'h800000, 1'b0, 7'd30,  8'd0, 1'b0},
        '{16'd14,  4'd6,  2'd1, 1'b0, 24'h000100, 1'b1, 7'd50,  8'd3, 1'b1},
        '{16'd126, 4'd7,  2'd2, 1'b0, 24'h7FFFFF, 1'b0, 7'd70,  8'd0, 1'b0},
        '{16'd6,   4'd0,  2'd3, 1'b1, 24'h000007, 1'b0, 7'd100, 8'd0, 1'b0}
    };

    logic        clk;
    logic        i_reset;
    logic        i_rx_kmsb;
    logic        i_rx_klsb;
    rx_word_t    i_rxd;
    logic        i_rx_start;
    addr_t       i_rx_base_addr;
    logic        i_link_loss_ena;
    logic        i_wr_cmd_ack;
    logic        o_wr_cmd_req;
    addr_t       o_wr_cmd_addr;
    byte_len_t   o_wr_cmd_bytes;
    logic        i_dma_wr_ready;
    logic        o_dma_wr_valid;
    beat_t       o_dma_wr_data;
    logic        o_frame_done;
    frame_info_t o_frame_info;
    logic        o_link_loss;

    // Expected responses, filled by the reference model before each frame is sent
    beat_t       exp_beats [$];
    addr_t       exp_cmd_addr [$];
    byte_len_t   exp_cmd_bytes [$];
    frame_info_t exp_infos [$];

    addr_t       model_addr;
    int unsigned ready_duty;
    int          frames_seen;
    int          cmds_seen;
    int          loss_pulses;
    int          cycle_count;

    rx_link_top #(
        .FIFO_DEPTH     (DEPTH_TB),
        .HOLDOFF_CYCLES (HOLDOFF_TB)
    ) i_rx_link_top (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_rx_kmsb       (i_rx_kmsb),
        .i_rx_klsb       (i_rx_klsb),
        .i_rxd           (i_rxd),
        .i_rx_start      (i_rx_start),
        .i_rx_base_addr  (i_rx_base_addr),
        .i_link_loss_ena (i_link_loss_ena),
        .i_wr_cmd_ack    (i_wr_cmd_ack),
        .o_wr_cmd_req    (o_wr_cmd_req),
        .o_wr_cmd_addr   (o_wr_cmd_addr),
        .o_wr_cmd_bytes  (o_wr_cmd_bytes),
        .i_dma_wr_ready  (i_dma_wr_ready),
        .o_dma_wr_valid  (o_dma_wr_valid),
        .o_dma_wr_data   (o_dma_wr_data),
        .o_frame_done    (o_frame_done),
        .o_frame_info    (o_frame_info),
        .o_link_loss     (o_link_loss)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Checker and helpers
    //////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, actual, expected);
            fail_run("value mismatch");
        end
    endtask

    // Request, address and byte count of the outstanding command
    task automatic verify_command(input addr_t addr, input byte_len_t bytes);
        check("o_wr_cmd_req", 64'(o_wr_cmd_req), 64'd1);
        check("o_wr_cmd_addr", 64'(o_wr_cmd_addr), 64'(addr));
        check("o_wr_cmd_bytes", 64'(o_wr_cmd_bytes), 64'(bytes));
    endtask

    function automatic int row_words(input frame_row_t row);
        // SOF, head flag and header take 6 words, check and the two end idles take 3
        return int'(row.idle) + 2 * int'(row.head_first) + SYNC_COUNT + 6
            + int'(row.len[15:1]) + 3;
    endfunction

    // One word per falling edge, with ready redrawn at the same time
    task automatic drive_word(input logic kmsb, input logic klsb, input logic [15:0] data);
        @(negedge clk);
        i_rx_kmsb      = kmsb;
        i_rx_klsb      = klsb;
        i_rxd          = data;
        i_dma_wr_ready = ($urandom_range(99, 0) < ready_duty);
    endtask

    // Random data with no K flag never matches a code word
    task automatic idle_word();
        drive_word(1'b0, 1'b0, 16'($urandom()));
    endtask

    //////////////////////////////
    // Reference model and serializer
    //////////////////////////////

    task automatic run_frame(input frame_row_t row);
        logic [15:0] data [$];
        logic [15:0] type_word;
        logic [15:0] sum;
        logic [15:0] bytes;
        beat_t       beat;
        frame_info_t info;
        int          n_words;
        int          i;
        int          b;
        int          k;
        n_words    = int'(row.len[15:1]);
        ready_duty = int'(row.duty);
        for (i = 0; i < n_words; i++) begin
            data.push_back(16'($urandom()));
        end
        // Lane k of beat b carries word 4b+k, missing words are zero
        for (b = 0; b < (n_words + 3) / 4; b++) begin
            beat = '0;
            for (k = 0; k < 4; k++) begin
                if (4 * b + k < n_words) begin
                    beat[16 * k +: 16] = data[4 * b + k];
                end
            end
            exp_beats.push_back(beat);
        end
        bytes = (row.len + 16'd7) & 16'hFFF8;
        exp_cmd_addr.push_back(model_addr);
        exp_cmd_bytes.push_back(bytes);
        model_addr = model_addr + 32'(bytes);
        info = '{file_end: row.fend, channel_id: row.chan, data_type: row.dtype,
                 line_number: row.line, length: row.len, checksum_error: row.corrupt};
        exp_infos.push_back(info);

        // Upper file end bit is random since it is not reported
        type_word = {1'($urandom()), row.fend, row.chan, row.dtype, row.line[23:16]};
        sum = type_word + row.line[15:0] + row.len;
        for (i = 0; i < n_words; i++) begin
            sum = sum + data[i];
        end
        repeat (int'(row.idle)) idle_word();
        if (row.head_first) begin
            drive_word(1'b0, 1'b0, HEAD_CODE[31:16]);
            drive_word(1'b0, 1'b0, HEAD_CODE[15:0]);
        end
        repeat (SYNC_COUNT) drive_word(1'b0, 1'b1, SYNC_CODE);
        drive_word(1'b1, 1'b1, SOF_CODE);
        drive_word(1'b0, 1'b0, HEAD_CODE[31:16]);
        drive_word(1'b0, 1'b0, HEAD_CODE[15:0]);
        drive_word(1'b0, 1'b0, type_word);
        drive_word(1'b0, 1'b0, row.line[15:0]);
        drive_word(1'b0, 1'b0, row.len);
        for (i = 0; i < n_words; i++) begin
            drive_word(1'b0, 1'b0, data[i]);
        end
        drive_word(1'b0, 1'b0, row.corrupt ? ~sum : sum);
        repeat (2) idle_word();
    endtask

    task automatic link_loss_test();
        ready_duty = 100;
        drive_word(1'b1, 1'b1, LOSS_CODE);
        repeat (3) idle_word();
        check("o_link_loss pulses", 64'(loss_pulses), 64'd1);
        // Inside the hold-off window
        drive_word(1'b1, 1'b1, LOSS_CODE);
        repeat (3) idle_word();
        check("o_link_loss pulses", 64'(loss_pulses), 64'd1);
        repeat (HOLDOFF_TB + 6) idle_word();
        drive_word(1'b1, 1'b1, LOSS_CODE);
        repeat (3) idle_word();
        check("o_link_loss pulses", 64'(loss_pulses), 64'd2);
    endtask

    //////////////////////////////
    // Responders and monitors
    //////////////////////////////

    initial begin : cmd_responder
        int unsigned delay;
        addr_t       exp_addr;
        byte_len_t   exp_bytes;
        i_wr_cmd_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (!i_reset && o_wr_cmd_req) begin
                if (exp_cmd_addr.size() == 0) begin
                    fail_run("write command request without a frame being sent");
                end else begin
                    exp_addr  = exp_cmd_addr.pop_front();
                    exp_bytes = exp_cmd_bytes.pop_front();
                    verify_command(exp_addr, exp_bytes);
                    cmds_seen++;
                    delay = $urandom_range(3, 0);
                    // Command must hold until the acknowledge
                    repeat (delay) begin
                        @(posedge clk);
                        verify_command(exp_addr, exp_bytes);
                    end
                    @(negedge clk);
                    i_wr_cmd_ack = 1'b1;
                    @(posedge clk);
                    verify_command(exp_addr, exp_bytes);
                    @(negedge clk);
                    i_wr_cmd_ack = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!i_reset) begin
            if (!i_dma_wr_ready) begin
                check("o_dma_wr_valid", 64'(o_dma_wr_valid), 64'd0);
            end
            if (o_dma_wr_valid) begin
                if (exp_beats.size() == 0) begin
                    fail_run("DMA beat written with no beat expected");
                end else begin
                    check("o_dma_wr_data", o_dma_wr_data, exp_beats.pop_front());
                end
            end
            if (o_frame_done) begin
                if (exp_infos.size() == 0) begin
                    fail_run("frame done pulse with no frame expected");
                end else begin
                    check("o_frame_info.checksum_error",
                          64'(o_frame_info.checksum_error),
                          64'(exp_infos[0].checksum_error));
                    check("o_frame_info", 64'(o_frame_info), 64'(exp_infos.pop_front()));
                    frames_seen++;
                end
            end
            if (o_link_loss) begin
                loss_pulses++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        int r;
        limit = LINK_TEST_WORDS + RESET_WORDS;
        for (r = 0; r < NUM_ROWS; r++) begin
            limit = limit + row_words(ROWS[r]);
        end
        limit       = limit * 4 + 500;
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > limit) begin
                fail_run("timeout, the DUT stopped producing the expected responses");
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : stimulus
        int r;
        void'($urandom(SEED));
        i_reset         = 1'b1;
        i_rx_kmsb       = 1'b0;
        i_rx_klsb       = 1'b0;
        i_rxd           = '0;
        i_rx_start      = 1'b0;
        i_rx_base_addr  = '0;
        i_link_loss_ena = 1'b0;
        i_dma_wr_ready  = 1'b0;
        ready_duty      = 100;
        frames_seen     = 0;
        cmds_seen       = 0;
        loss_pulses     = 0;
        model_addr      = BASE_ADDR;
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_reset        = 1'b0;
        // Ready high so that valid shows the FIFO empty state
        i_dma_wr_ready = 1'b1;
        @(negedge clk);
        check("o_wr_cmd_req", 64'(o_wr_cmd_req), 64'd0);
        check("o_dma_wr_valid", 64'(o_dma_wr_valid), 64'd0);
        check("o_frame_done", 64'(o_frame_done), 64'd0);
        check("o_link_loss", 64'(o_link_loss), 64'd0);
        i_rx_base_addr  = BASE_ADDR;
        i_rx_start      = 1'b1;
        i_link_loss_ena = 1'b1;
        @(negedge clk);
        i_rx_start = 1'b0;

        for (r = 0; r < NUM_ROWS; r++) begin
            run_frame(ROWS[r]);
        end
        // Drain with ready held high
        ready_duty = 100;
        while (exp_beats.size() != 0 || exp_infos.size() != 0 || exp_cmd_addr.size() != 0) begin
            idle_word();
        end
        link_loss_test();
        repeat (8) idle_word();

        if (frames_seen == NUM_ROWS && cmds_seen == NUM_ROWS && loss_pulses == 2) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("frame, command or link-loss count differs from the frame table");
        end
    end

endmodule

/* build.f */
rtl/rx_link_pkg.sv
rtl/frame_parser.sv
rtl/word_packer.sv
rtl/beat_fifo.sv
rtl/dma_cmd_gen.sv
rtl/link_loss_monitor.sv
rtl/rx_link_top.sv
verif/rx_link_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= rx_link_tb
RTL_TOP   ?= rx_link_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# The run exits nonzero on $fatal, which fails this target
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
